//--- rtl/ppu_pkg.sv
package ppu_pkg;

    // frame geometry
    localparam int DOTS_PER_LINE   = 341;
    localparam int LAST_DOT        = DOTS_PER_LINE - 1;
    localparam int LINES_PER_FRAME = 262;
    localparam int LAST_LINE       = LINES_PER_FRAME - 1;
    localparam int VISIBLE_DOTS    = 256;
    localparam int POST_LINE       = 241;  // post-render line, vblank begins here
    localparam int CLIP_DOTS       = 8;    // left clip width
    localparam int NMI_DOTS        = 3;    // interrupt pulse length in dots

    // widths
    localparam int DOT_W      = 9;  // dot and line counters
    localparam int PIX_IDX_W  = 4;
    localparam int PAL_ADDR_W = 5;
    localparam int COLOR_W    = 6;

    localparam logic [COLOR_W-1:0] GREY_MASK = 6'h30;  // keep luma bits only

    // cpu register indices
    localparam logic [2:0] REG_CTRL     = 3'd0;
    localparam logic [2:0] REG_MASK     = 3'd1;
    localparam logic [2:0] REG_STATUS   = 3'd2;
    localparam logic [2:0] REG_PAL_ADDR = 3'd6;
    localparam logic [2:0] REG_PAL_DATA = 3'd7;

    // bit positions within the registers
    localparam int CTRL_NMI_EN  = 7;
    localparam int MASK_GREY    = 0;
    localparam int MASK_BG_LEFT = 1;
    localparam int MASK_SP_LEFT = 2;
    localparam int MASK_BG_EN   = 3;
    localparam int MASK_SP_EN   = 4;
    localparam int STAT_VBLANK  = 7;
    localparam int STAT_SP_ZERO = 6;

    typedef enum logic [1:0] {PRE_LINE, VIS_LINE, POST_LINE_PH, VBLANK_LINE} vphase_t;

    // field order matches the bit positions above, grey in bit 0
    typedef struct packed {
        logic [2:0] unused;
        logic       sp_en;
        logic       bg_en;
        logic       sp_left;
        logic       bg_left;
        logic       grey;
    } mask_t;

endpackage

//--- rtl/beam_if.sv
`timescale 1ns/1ps

interface beam_if import ppu_pkg::*; ();

    logic [DOT_W-1:0] dot;
    logic [DOT_W-1:0] line;
    vphase_t          phase;
    logic             pre_clear;     // line 0, dot 0
    logic             vblank_start;  // line 241, dot 0
    logic             nmi_window;    // dots 0..2 of line 241
    logic             visible;

    modport source (output dot, line, phase, pre_clear, vblank_start, nmi_window, visible);

    modport events (input pre_clear, vblank_start, nmi_window);

    modport pixel (input dot, visible);

endinterface

//--- rtl/pal_if.sv
`timescale 1ns/1ps

interface pal_if import ppu_pkg::*; ();

    logic [PAL_ADDR_W-1:0] addr;
    logic                  we;     // one-clock write strobe
    logic                  re;     // one-clock read strobe
    logic [COLOR_W-1:0]    wdata;
    logic [COLOR_W-1:0]    rdata;  // async read back from the store

    // register block side
    modport cpu (output addr, we, re, wdata, input rdata);

    // palette store side
    modport mem (input addr, we, re, wdata, output rdata);

endinterface

//--- rtl/ppu_timing.sv
`timescale 1ns/1ps

module ppu_timing import ppu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ppu_clk_en,
    beam_if.source beam
);

    logic [DOT_W-1:0] dot;
    logic [DOT_W-1:0] line;
    vphase_t          phase;
    vphase_t          phase_nx;
    logic             end_of_line;

    assign end_of_line = (dot == LAST_DOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot   <= '0;
            line  <= '0;
            phase <= PRE_LINE;
        end else if (ppu_clk_en) begin
            phase <= phase_nx;
            if (end_of_line) begin
                dot  <= '0;
                line <= (line == LAST_LINE) ? '0 : line + 1'b1;  // frame wrap
            end else begin
                dot <= dot + 1'b1;
            end
        end
    end

    // phase only moves on the last dot of a line
    always_comb begin
        phase_nx = phase;
        if (end_of_line) begin
            case (phase)
                PRE_LINE: begin
                    if (line == '0)
                        phase_nx = VIS_LINE;
                end
                VIS_LINE: begin
                    if (line == POST_LINE - 1)
                        phase_nx = POST_LINE_PH;
                end
                POST_LINE_PH: phase_nx = VBLANK_LINE;  // single post line
                VBLANK_LINE: begin
                    if (line == LAST_LINE)
                        phase_nx = PRE_LINE;
                end
                default: phase_nx = PRE_LINE;
            endcase
        end
    end

    assign beam.dot          = dot;
    assign beam.line         = line;
    assign beam.phase        = phase;
    assign beam.pre_clear    = (phase == PRE_LINE) && (dot == '0);
    assign beam.vblank_start = (phase == POST_LINE_PH) && (dot == '0);
    assign beam.nmi_window   = (phase == POST_LINE_PH) && (dot < NMI_DOTS);
    assign beam.visible      = (phase == VIS_LINE) && (dot < VISIBLE_DOTS);

    a_beam_range: assert property (@(posedge clk) disable iff (!rst_n)
        (dot <= LAST_DOT) && (line <= LAST_LINE));

endmodule

//--- rtl/ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ppu_clk_en,
    input  logic [2:0] reg_sel,
    input  logic       reg_en,
    input  logic       reg_rw,       // 1 write, 0 read
    input  logic [7:0] reg_data_in,
    output logic [7:0] reg_data_out,
    output logic       vblank_nmi,   // active low
    beam_if.events     beam,
    pal_if.cpu         pal,
    output mask_t      mask,
    input  logic       sp_zero_hit
);

    logic                  nmi_en;
    logic                  vblank;
    logic                  sp_zero_flag;
    logic [PAL_ADDR_W-1:0] pal_ptr;
    logic                  reg_wr;
    logic                  reg_rd;
    logic [7:0]            rd_val;

    assign reg_wr = reg_en && reg_rw;
    assign reg_rd = reg_en && !reg_rw;

    // data register goes straight to the palette store at the pointer
    assign pal.addr  = pal_ptr;
    assign pal.we    = reg_wr && (reg_sel == REG_PAL_DATA);
    assign pal.re    = reg_rd && (reg_sel == REG_PAL_DATA);
    assign pal.wdata = reg_data_in[COLOR_W-1:0];

    always_comb begin
        rd_val = '0;
        case (reg_sel)
            REG_STATUS: begin
                rd_val[STAT_VBLANK]  = vblank;
                rd_val[STAT_SP_ZERO] = sp_zero_flag;  // overflow bit stays 0
            end
            REG_PAL_DATA: rd_val = {{(8 - COLOR_W){1'b0}}, pal.rdata};
            default: rd_val = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_en       <= 1'b0;
            mask         <= '0;
            pal_ptr      <= '0;
            reg_data_out <= '0;
        end else begin
            if (reg_wr && reg_sel == REG_CTRL)
                nmi_en <= reg_data_in[CTRL_NMI_EN];
            if (reg_wr && reg_sel == REG_MASK) begin
                mask.grey    <= reg_data_in[MASK_GREY];
                mask.bg_left <= reg_data_in[MASK_BG_LEFT];
                mask.sp_left <= reg_data_in[MASK_SP_LEFT];
                mask.bg_en   <= reg_data_in[MASK_BG_EN];
                mask.sp_en   <= reg_data_in[MASK_SP_EN];
                mask.unused  <= '0;
            end
            if (reg_wr && reg_sel == REG_PAL_ADDR)
                pal_ptr <= reg_data_in[PAL_ADDR_W-1:0];
            else if (pal.we || pal.re)
                pal_ptr <= pal_ptr + 1'b1;  // wraps at 32
            if (reg_rd)
                reg_data_out <= rd_val;     // held until next read
        end
    end

    // status flags, later assignments win
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank       <= 1'b0;
            sp_zero_flag <= 1'b0;
        end else begin
            if (reg_rd && reg_sel == REG_STATUS)
                vblank <= 1'b0;  // read clears vblank
            if (ppu_clk_en && beam.vblank_start)
                vblank <= 1'b1;
            if (sp_zero_hit)
                sp_zero_flag <= 1'b1;
            if (ppu_clk_en && beam.pre_clear) begin
                vblank       <= 1'b0;
                sp_zero_flag <= 1'b0;
            end
        end
    end

    assign vblank_nmi = !(beam.nmi_window && nmi_en);

    a_rw_known: assert property (@(posedge clk) disable iff (!rst_n)
        reg_en |-> !$isunknown(reg_rw));

endmodule

//--- rtl/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer import ppu_pkg::*; (
    input  logic                  ppu_clk_en,
    beam_if.pixel                 beam,
    input  mask_t                 mask,
    input  logic [PIX_IDX_W-1:0]  bg_idx,
    input  logic [PIX_IDX_W-1:0]  sp_idx,
    input  logic                  sp_prio,     // 1 puts sprite behind background
    input  logic                  sp_zero,     // pixel comes from sprite 0
    output logic [PAL_ADDR_W-1:0] render_addr,
    output logic                  sp_zero_hit
);

    logic [PIX_IDX_W-1:0] bg_m;
    logic [PIX_IDX_W-1:0] sp_m;
    logic                 in_clip;
    logic                 bg_opaque;
    logic                 sp_opaque;

    assign in_clip = (beam.dot < CLIP_DOTS);

    // layer enables and left-edge clip
    assign bg_m = (!mask.bg_en || (in_clip && !mask.bg_left)) ? '0 : bg_idx;
    assign sp_m = (!mask.sp_en || (in_clip && !mask.sp_left)) ? '0 : sp_idx;

    // low two bits zero means transparent
    assign bg_opaque = |bg_m[1:0];
    assign sp_opaque = |sp_m[1:0];

    always_comb begin
        if (sp_opaque && (!bg_opaque || !sp_prio))
            render_addr = {1'b1, sp_m};  // sprite half of the palette
        else
            render_addr = {1'b0, bg_m};
    end

    // no hit on the last visible dot
    assign sp_zero_hit = ppu_clk_en && beam.visible && (beam.dot < VISIBLE_DOTS - 1)
                         && sp_zero && bg_opaque && sp_opaque;

endmodule

//--- rtl/pal_ram.sv
`timescale 1ns/1ps

module pal_ram import ppu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ppu_clk_en,
    beam_if.pixel                 beam,
    pal_if.mem                    pal,
    input  logic [PAL_ADDR_W-1:0] render_addr,
    input  mask_t                 mask,
    output logic                  pixel_valid,
    output logic [COLOR_W-1:0]    pixel_color
);

    logic [COLOR_W-1:0]    mem [2**PAL_ADDR_W];
    logic [PAL_ADDR_W-1:0] addr;
    logic [COLOR_W-1:0]    lookup;

    // single port, cpu access wins over render
    assign addr      = (pal.we || pal.re) ? pal.addr : render_addr;
    assign lookup    = mem[addr];
    assign pal.rdata = lookup;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**PAL_ADDR_W; i++)
                mem[i] <= '0;
        end else if (pal.we) begin
            mem[addr] <= pal.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            pixel_color <= '0;
        end else begin
            pixel_valid <= ppu_clk_en && beam.visible;  // one clk per sampled dot
            if (ppu_clk_en)
                pixel_color <= mask.grey ? (lookup & GREY_MASK) : lookup;
        end
    end

    a_no_we_re: assert property (@(posedge clk) disable iff (!rst_n)
        !(pal.we && pal.re));

endmodule

//--- rtl/ppu_core.sv
`timescale 1ns/1ps

module ppu_core import ppu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ppu_clk_en,
    // cpu register port
    input  logic [2:0]           reg_sel,
    input  logic                 reg_en,
    input  logic                 reg_rw,
    input  logic [7:0]           reg_data_in,
    output logic [7:0]           reg_data_out,
    output logic                 vblank_nmi,
    // per-dot layer pixels
    input  logic [PIX_IDX_W-1:0] bg_idx,
    input  logic [PIX_IDX_W-1:0] sp_idx,
    input  logic                 sp_prio,
    input  logic                 sp_zero,
    output logic                 pixel_valid,
    output logic [COLOR_W-1:0]   pixel_color
);

    mask_t                 mask;
    logic [PAL_ADDR_W-1:0] render_addr;
    logic                  sp_zero_hit;

    beam_if beam ();
    pal_if  pal ();

    ppu_timing u_timing (.clk, .rst_n, .ppu_clk_en, .beam(beam.source));

    ppu_regs u_regs (
        .clk, .rst_n, .ppu_clk_en,
        .reg_sel, .reg_en, .reg_rw, .reg_data_in, .reg_data_out,
        .vblank_nmi,
        .beam(beam.events),
        .pal(pal.cpu),
        .mask,
        .sp_zero_hit
    );

    pixel_mixer u_mixer (
        .ppu_clk_en, .beam(beam.pixel), .mask,
        .bg_idx, .sp_idx, .sp_prio, .sp_zero,
        .render_addr, .sp_zero_hit
    );

    pal_ram u_pal (
        .clk, .rst_n, .ppu_clk_en,
        .beam(beam.pixel), .pal(pal.mem),
        .render_addr, .mask,
        .pixel_valid, .pixel_color
    );

endmodule

//--- verification/tb_ppu_core.sv
`timescale 1ns/1ps

module tb_ppu_core;
    import ppu_pkg::*;

    localparam int MAX_OPS = 128;
    localparam int PERIOD  = 100;

    logic                 clk;
    logic                 rst_n;
    logic                 ppu_clk_en;
    logic [2:0]           reg_sel;
    logic                 reg_en;
    logic                 reg_rw;
    logic [7:0]           reg_data_in;
    logic [7:0]           reg_data_out;
    logic                 vblank_nmi;
    logic [PIX_IDX_W-1:0] bg_idx;
    logic [PIX_IDX_W-1:0] sp_idx;
    logic                 sp_prio;
    logic                 sp_zero;
    logic                 pixel_valid;
    logic [COLOR_W-1:0]   pixel_color;

    string       t_name [MAX_OPS];
    string       t_op [MAX_OPS];
    logic [31:0] t_arg [MAX_OPS][4];
    string       cur_name;
    int          n_ops;
    int          test_errs;
    int          passed;
    int          failed;
    logic        held;  // pixel inputs pinned by a dot op

    ppu_core dut0 (
        .clk, .rst_n, .ppu_clk_en,
        .reg_sel, .reg_en, .reg_rw, .reg_data_in, .reg_data_out,
        .vblank_nmi,
        .bg_idx, .sp_idx, .sp_prio, .sp_zero,
        .pixel_valid, .pixel_color
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // inputs change and outputs are read 10 ns after the edge
    task automatic clk_step();
        @(posedge clk);
        #10;
    endtask

    task automatic reg_access(input logic rw, input logic [2:0] sel, input logic [7:0] data);
        reg_en      = 1'b1;
        reg_rw      = rw;
        reg_sel     = sel;
        reg_data_in = data;
        clk_step();
        reg_en = 1'b0;
        reg_rw = 1'b0;
    endtask

    task automatic run_dots(input int n, input int gap);
        for (int k = 0; k < n; k++) begin
            if (!held) begin
                bg_idx = PIX_IDX_W'($urandom);
                sp_idx = PIX_IDX_W'($urandom);
            end
            ppu_clk_en = 1'b0;
            repeat (gap) clk_step();  // stalled clocks consume no dot
            ppu_clk_en = 1'b1;
            clk_step();
            ppu_clk_en = 1'b0;
        end
    endtask

    task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("ERR %s: expected %0h, got %0h", cur_name, expected, actual);
        test_errs++;
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout: run still going after %0d clock cycles", cycles);
        $display("TB FAILED");
        $finish;
    endtask

    function automatic int arg_count(input string op);
        case (op)
            "wr", "rd", "run": return 2;
            "dot":             return 4;
            "nmi":             return 1;
            default:           return 0;
        endcase
    endfunction

    initial begin
        int    fd;
        int    code;
        int    ch;
        int    budget;
        string word;

        rst_n       = 1'b0;
        ppu_clk_en  = 1'b0;
        reg_sel     = '0;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_data_in = '0;
        bg_idx      = '0;
        sp_idx      = '0;
        sp_prio     = 1'b0;
        sp_zero     = 1'b0;
        held        = 1'b0;
        test_errs   = 0;
        passed      = 0;
        failed      = 0;
        n_ops       = 0;
        void'($urandom(43));

        fd = $fopen("verification/ppu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/ppu_golden.txt");
            failed++;
        end else begin
            while (n_ops < MAX_OPS) begin
                code = $fscanf(fd, "%s", word);
                if (code != 1)
                    break;
                if (word == "#") begin
                    do
                        ch = $fgetc(fd);  // skip comment line
                    while (ch != 10 && ch != -1);
                end else begin
                    t_name[n_ops] = word;
                    code = $fscanf(fd, "%s", t_op[n_ops]);
                    for (int j = 0; j < arg_count(t_op[n_ops]); j++)
                        code = $fscanf(fd, "%h", t_arg[n_ops][j]);
                    n_ops++;
                end
            end
            $fclose(fd);
        end

        // run length from the file with stalls and a 10 percent margin
        budget = 16;
        for (int i = 0; i < n_ops; i++)
            budget += (t_op[i] == "run") ? t_arg[i][0] * (1 + t_arg[i][1]) : 2;
        fork
            watchdog(budget + budget / 10);
        join_none

        repeat (16) clk_step();
        rst_n = 1'b1;

        for (int i = 0; i < n_ops; i++) begin
            cur_name = t_name[i];
            case (t_op[i])
                "wr":  reg_access(1'b1, 3'(t_arg[i][0]), 8'(t_arg[i][1]));
                "run": run_dots(t_arg[i][0], t_arg[i][1]);
                "rd": begin
                    reg_access(1'b0, 3'(t_arg[i][0]), 8'h00);
                    if (reg_data_out !== 8'(t_arg[i][1]))
                        report_mismatch(t_arg[i][1], 32'(reg_data_out));
                end
                "dot": begin
                    held    = 1'b1;
                    bg_idx  = PIX_IDX_W'(t_arg[i][0]);
                    sp_idx  = PIX_IDX_W'(t_arg[i][1]);
                    sp_prio = t_arg[i][2][1];
                    sp_zero = t_arg[i][2][0];
                    run_dots(1, 0);
                    if (pixel_valid !== 1'b1) begin
                        $display("%s: no pixel came out for a visible dot", cur_name);
                        test_errs++;
                    end else if (pixel_color !== COLOR_W'(t_arg[i][3])) begin
                        report_mismatch(t_arg[i][3], 32'(pixel_color));
                    end
                end
                "idle": begin
                    run_dots(1, 0);
                    if (pixel_valid !== 1'b0) begin
                        $display("%s: pixel marked valid outside the visible area", cur_name);
                        test_errs++;
                    end
                end
                "rel": begin
                    held    = 1'b0;
                    sp_prio = 1'b0;
                    sp_zero = 1'b0;
                end
                "nmi": begin
                    if (vblank_nmi !== t_arg[i][0][0])
                        report_mismatch(t_arg[i][0], 32'(vblank_nmi));
                end
                default: begin
                    $display("%s: unknown operation %s in the golden file", cur_name, t_op[i]);
                    test_errs++;
                end
            endcase
            if (i == n_ops - 1 || t_name[i + 1] != cur_name) begin
                if (test_errs == 0) begin
                    passed++;
                    $display("test %s: ok", cur_name);
                end else begin
                    failed++;
                    $display("test %s: %0d error(s)", cur_name, test_errs);
                end
                test_errs = 0;
            end
        end

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && n_ops > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/ppu_pkg.sv
rtl/beam_if.sv
rtl/pal_if.sv
rtl/ppu_timing.sv
rtl/ppu_regs.sv
rtl/pixel_mixer.sv
rtl/pal_ram.sv
rtl/ppu_core.sv
verification/tb_ppu_core.sv

//--- Bender.yml
package:
  name: ppu_core

sources:
  - rtl/ppu_pkg.sv
  - rtl/beam_if.sv
  - rtl/pal_if.sv
  - rtl/ppu_timing.sv
  - rtl/ppu_regs.sv
  - rtl/pixel_mixer.sv
  - rtl/pal_ram.sv
  - rtl/ppu_core.sv
  - target: test
    files:
      - verification/tb_ppu_core.sv

//--- verification/ppu_golden.txt
# test op args (hex): wr sel data | rd sel expect | run dots stall | nmi level
# dot bg sp flags(prio,zero) colour | idle (no pixel expected) | rel (free pixel inputs)
rst rd 2 0
rst nmi 1
rst idle
pal wr 6 1f
pal wr 7 11
pal wr 7 5
pal wr 7 2a
pal wr 6 1f
pal rd 7 11
pal rd 7 5
pal rd 7 2a
mix run 154 0
mix wr 1 1e
mix dot 1 f 0 11
mix dot 1 f 2 2a
mix wr 1 18
mix dot 1 f 2 5
mix wr 1 1f
mix dot 0 f 0 10
sz dot 1 8 1 20
sz run fa 0
sz dot 1 f 1 10
sz rd 2 0
sz rel
sz run 55 0
sz dot 1 f 1 10
sz rd 2 40
sz rel
frm wr 0 80
frm run 13e59 0
frm nmi 1
frm run 1 0
frm nmi 0
frm run 1 3
frm nmi 0
frm run 1 3
frm nmi 0
frm run 1 2
frm nmi 1
frm rd 2 c0
frm rd 2 40
frm run 1bf7 0
frm rd 2 0
